// File: source/soc_map_consts.svh
// --------------------
// SoC map constants
// --------------------

`ifndef SOC_MAP_CONSTS_SVH
`define SOC_MAP_CONSTS_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 64

// APB side of the bridge
`define APB_ADDR_W 32
`define APB_DATA_W 32

// Request buffer depth, also the initial credit count
`define FABRIC_DEPTH 4

// --------------------
// Memory map windows
`define ROM_BASE  32'h0001_0000
`define ROM_LEN   32'h0001_0000

`define APB_BASE  32'h6000_0000
`define APB_LEN   32'h1000_0000

`define DRAM_BASE 32'h8000_0000
`define DRAM_LEN  32'h2000_0000

`endif

// File: source/map_pkg.sv
// --------------------
// Memory map types
// --------------------

`include "soc_map_consts.svh"

package map_pkg;

   // Decoded destination of a request
   typedef enum logic [1:0] {
      TGT_ROM  = 2'd0,
      TGT_APB  = 2'd1,
      TGT_DRAM = 2'd2,
      TGT_NONE = 2'd3
   } target_t;

   // Address relative to the base of its window
   typedef logic [`SOC_ADDR_W-1:0] offset_t;

endpackage

// File: source/bus_pkg.sv
// --------------------
// Transaction types
// --------------------

`include "soc_map_consts.svh"

package bus_pkg;

   typedef logic [`SOC_ADDR_W-1:0] addr_t;
   typedef logic [`SOC_DATA_W-1:0] data_t;

   // Master side request, 97 bits
   typedef struct packed {
      logic  write;
      addr_t addr;
      data_t data;
   } bus_req_t;

   // Response to the master, 65 bits
   typedef struct packed {
      data_t data;
      logic  err;
   } bus_rsp_t;

   // Memory port request with window offset, 97 bits
   typedef struct packed {
      logic             write;
      map_pkg::offset_t offset;
      data_t            data;
   } mem_req_t;

   // One APB transfer, 65 bits
   typedef struct packed {
      logic                   write;
      logic [`APB_ADDR_W-1:0] addr;
      logic [`APB_DATA_W-1:0] wdata;
   } apb_cmd_t;

endpackage

// File: source/addr_decoder.sv
// --------------------
// Address decoder
// --------------------

`include "soc_map_consts.svh"

module addr_decoder (
   input  bus_pkg::addr_t   addr_i,
   output map_pkg::target_t target_o,
   output map_pkg::offset_t offset_o
);

   map_pkg::offset_t rom_off;
   map_pkg::offset_t apb_off;
   map_pkg::offset_t dram_off;

   // Unsigned offset below length means the address is inside the window
   assign rom_off  = addr_i - `ROM_BASE;
   assign apb_off  = addr_i - `APB_BASE;
   assign dram_off = addr_i - `DRAM_BASE;

   always_comb begin
      target_o = map_pkg::TGT_NONE;
      offset_o = '0;
      if (rom_off < `ROM_LEN) begin
         target_o = map_pkg::TGT_ROM;
         offset_o = rom_off;
      end else if (apb_off < `APB_LEN) begin
         target_o = map_pkg::TGT_APB;
         offset_o = apb_off;
      end else if (dram_off < `DRAM_LEN) begin
         target_o = map_pkg::TGT_DRAM;
         offset_o = dram_off;
      end
   end

endmodule

// File: source/req_fifo.sv
// --------------------
// Request buffer
// --------------------

`include "soc_map_consts.svh"

module req_fifo (
   input  logic              clk,
   input  logic              rst_n_i,
   input  logic              push_i,
   input  bus_pkg::bus_req_t push_data_i,
   input  logic              pop_i,
   output bus_pkg::bus_req_t head_o,
   output logic              empty_o
);

   localparam int DEPTH = `FABRIC_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   bus_pkg::bus_req_t mem_q [DEPTH];

   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;

   // Storage
   always_ff @(posedge clk) begin
      if (push_i) begin
         mem_q[wr_ptr_q] <= push_data_i;
      end
   end

   // Pointers and fill level
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop_i) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         case ({push_i, pop_i})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   assign head_o  = mem_q[rd_ptr_q];
   assign empty_o = (count_q == '0);

endmodule

// File: source/apb_bridge.sv
// --------------------
// APB bridge
// --------------------

`include "soc_map_consts.svh"

module apb_bridge (
   input  logic                   clk,
   input  logic                   rst_n_i,
   input  logic                   start_i,
   input  bus_pkg::apb_cmd_t      cmd_i,
   output logic                   done_o,
   output logic [`APB_DATA_W-1:0] rdata_o,
   output logic                   err_o,
   output logic                   psel_o,
   output logic                   penable_o,
   output logic                   pwrite_o,
   output logic [`APB_ADDR_W-1:0] paddr_o,
   output logic [`APB_DATA_W-1:0] pwdata_o,
   input  logic [`APB_DATA_W-1:0] prdata_i,
   input  logic                   pready_i,
   input  logic                   pslverr_i
);

   typedef enum logic [1:0] {
      IDLE,
      SETUP,
      ACCESS
   } state_t;

   state_t            state_q;
   bus_pkg::apb_cmd_t cmd_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
      end else begin
         case (state_q)
            IDLE: begin
               if (start_i) begin
                  state_q <= SETUP;
               end
            end
            SETUP: begin
               state_q <= ACCESS;
            end
            ACCESS: begin
               // Wait states until the slave is ready
               if (pready_i) begin
                  state_q <= IDLE;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Command held for the whole transfer
   always_ff @(posedge clk) begin
      if (start_i && (state_q == IDLE)) begin
         cmd_q <= cmd_i;
      end
   end

   assign psel_o    = (state_q != IDLE);
   assign penable_o = (state_q == ACCESS);
   assign pwrite_o  = cmd_q.write;
   assign paddr_o   = cmd_q.addr;
   assign pwdata_o  = cmd_q.wdata;

   // Completion in the pready cycle, sampled by the controller
   assign done_o  = (state_q == ACCESS) && pready_i;
   assign rdata_o = prdata_i;
   assign err_o   = pslverr_i;

endmodule

// File: source/fabric_ctrl.sv
// --------------------
// Fabric controller
// --------------------

`include "soc_map_consts.svh"

module fabric_ctrl (
   input  logic                   clk,
   input  logic                   rst_n_i,
   input  logic                   empty_i,
   input  bus_pkg::bus_req_t      head_i,
   input  map_pkg::target_t       target_i,
   input  map_pkg::offset_t       offset_i,
   output logic                   pop_o,
   output logic                   credit_o,
   output logic                   rom_req_valid_o,
   output bus_pkg::mem_req_t      rom_req_o,
   input  logic                   rom_rsp_valid_i,
   input  bus_pkg::data_t         rom_rsp_data_i,
   output logic                   dram_req_valid_o,
   output bus_pkg::mem_req_t      dram_req_o,
   input  logic                   dram_rsp_valid_i,
   input  bus_pkg::data_t         dram_rsp_data_i,
   output logic                   apb_start_o,
   output bus_pkg::apb_cmd_t      apb_cmd_o,
   input  logic                   apb_done_i,
   input  logic [`APB_DATA_W-1:0] apb_rdata_i,
   input  logic                   apb_err_i,
   output logic                   rsp_valid_o,
   output bus_pkg::bus_rsp_t      rsp_o
);

   typedef enum logic [2:0] {
      IDLE,
      MEM_WAIT,
      APB_WAIT,
      ERR_RSP,
      RESPOND
   } state_t;

   state_t            state_q;
   state_t            state_d;
   map_pkg::target_t  tgt_q;
   bus_pkg::mem_req_t req_q;
   bus_pkg::bus_rsp_t rsp_q;
   logic              mem_done;
   bus_pkg::data_t    mem_rdata;

   // --------------------
   // Dispatch
   assign pop_o       = (state_q == IDLE) && !empty_i;
   assign credit_o    = pop_o;
   assign apb_start_o = pop_o && (target_i == map_pkg::TGT_APB);
   assign apb_cmd_o   = '{write: head_i.write,
                          addr:  offset_i[`APB_ADDR_W-1:0],
                          wdata: head_i.data[`APB_DATA_W-1:0]};

   assign mem_done  = (tgt_q == map_pkg::TGT_ROM) ? rom_rsp_valid_i : dram_rsp_valid_i;
   assign mem_rdata = (tgt_q == map_pkg::TGT_ROM) ? rom_rsp_data_i : dram_rsp_data_i;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (!empty_i) begin
               case (target_i)
                  map_pkg::TGT_ROM,
                  map_pkg::TGT_DRAM: state_d = MEM_WAIT;
                  map_pkg::TGT_APB:  state_d = APB_WAIT;
                  default:           state_d = ERR_RSP;
               endcase
            end
         end
         MEM_WAIT: if (mem_done) state_d = RESPOND;
         APB_WAIT: if (apb_done_i) state_d = RESPOND;
         ERR_RSP:  state_d = RESPOND;
         default:  state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
         tgt_q   <= map_pkg::TGT_NONE;
      end else begin
         state_q <= state_d;
         if (pop_o) begin
            tgt_q <= target_i;
         end
      end
   end

   // Request and response payload
   always_ff @(posedge clk) begin
      if (pop_o) begin
         req_q <= '{write: head_i.write, offset: offset_i, data: head_i.data};
      end
      if ((state_q == MEM_WAIT) && mem_done) begin
         rsp_q <= '{data: mem_rdata, err: 1'b0};
      end else if ((state_q == APB_WAIT) && apb_done_i) begin
         rsp_q <= '{data: {{(`SOC_DATA_W - `APB_DATA_W){1'b0}}, apb_rdata_i}, err: apb_err_i};
      end else if (state_q == ERR_RSP) begin
         rsp_q <= '{data: '0, err: 1'b1};
      end
   end

   // --------------------
   // Target and master outputs
   assign rom_req_valid_o  = (state_q == MEM_WAIT) && (tgt_q == map_pkg::TGT_ROM);
   assign dram_req_valid_o = (state_q == MEM_WAIT) && (tgt_q == map_pkg::TGT_DRAM);
   assign rom_req_o        = req_q;
   assign dram_req_o       = req_q;

   assign rsp_valid_o = (state_q == RESPOND);
   assign rsp_o       = rsp_q;

endmodule

// File: source/soc_fabric.sv
// --------------------
// SoC fabric top
// --------------------

`include "soc_map_consts.svh"

module soc_fabric (
   input  logic                   clk,
   input  logic                   rst_n_i,
   // Master
   input  logic                   req_valid_i,
   input  bus_pkg::bus_req_t      req_i,
   output logic                   credit_o,
   output logic                   rsp_valid_o,
   output bus_pkg::bus_rsp_t      rsp_o,
   // ROM
   output logic                   rom_req_valid_o,
   output bus_pkg::mem_req_t      rom_req_o,
   input  logic                   rom_rsp_valid_i,
   input  bus_pkg::data_t         rom_rsp_data_i,
   // DRAM
   output logic                   dram_req_valid_o,
   output bus_pkg::mem_req_t      dram_req_o,
   input  logic                   dram_rsp_valid_i,
   input  bus_pkg::data_t         dram_rsp_data_i,
   // APB
   output logic                   psel_o,
   output logic                   penable_o,
   output logic                   pwrite_o,
   output logic [`APB_ADDR_W-1:0] paddr_o,
   output logic [`APB_DATA_W-1:0] pwdata_o,
   input  logic [`APB_DATA_W-1:0] prdata_i,
   input  logic                   pready_i,
   input  logic                   pslverr_i
);

   bus_pkg::bus_req_t      fifo_head;
   logic                   fifo_empty;
   logic                   fifo_pop;
   map_pkg::target_t       head_target;
   map_pkg::offset_t       head_offset;
   logic                   apb_start;
   bus_pkg::apb_cmd_t      apb_cmd;
   logic                   apb_done;
   logic [`APB_DATA_W-1:0] apb_rdata;
   logic                   apb_err;

   req_fifo i_req_fifo (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .push_i      (req_valid_i),
      .push_data_i (req_i),
      .pop_i       (fifo_pop),
      .head_o      (fifo_head),
      .empty_o     (fifo_empty)
   );

   // Decode the request at the head of the buffer
   addr_decoder i_addr_decoder (
      .addr_i   (fifo_head.addr),
      .target_o (head_target),
      .offset_o (head_offset)
   );

   fabric_ctrl i_fabric_ctrl (
      .clk              (clk),
      .rst_n_i          (rst_n_i),
      .empty_i          (fifo_empty),
      .head_i           (fifo_head),
      .target_i         (head_target),
      .offset_i         (head_offset),
      .pop_o            (fifo_pop),
      .credit_o         (credit_o),
      .rom_req_valid_o  (rom_req_valid_o),
      .rom_req_o        (rom_req_o),
      .rom_rsp_valid_i  (rom_rsp_valid_i),
      .rom_rsp_data_i   (rom_rsp_data_i),
      .dram_req_valid_o (dram_req_valid_o),
      .dram_req_o       (dram_req_o),
      .dram_rsp_valid_i (dram_rsp_valid_i),
      .dram_rsp_data_i  (dram_rsp_data_i),
      .apb_start_o      (apb_start),
      .apb_cmd_o        (apb_cmd),
      .apb_done_i       (apb_done),
      .apb_rdata_i      (apb_rdata),
      .apb_err_i        (apb_err),
      .rsp_valid_o      (rsp_valid_o),
      .rsp_o            (rsp_o)
   );

   apb_bridge i_apb_bridge (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .start_i   (apb_start),
      .cmd_i     (apb_cmd),
      .done_o    (apb_done),
      .rdata_o   (apb_rdata),
      .err_o     (apb_err),
      .psel_o    (psel_o),
      .penable_o (penable_o),
      .pwrite_o  (pwrite_o),
      .paddr_o   (paddr_o),
      .pwdata_o  (pwdata_o),
      .prdata_i  (prdata_i),
      .pready_i  (pready_i),
      .pslverr_i (pslverr_i)
   );

endmodule

// File: dv/soc_fabric_assert.sv
// --------------------
// Fabric protocol checks
// --------------------

`include "soc_map_consts.svh"

module soc_fabric_assert (
   input logic              clk,
   input logic              rst_n_i,
   input logic              req_valid_i,
   input logic              fifo_pop,
   input logic              psel_o,
   input logic              penable_o,
   input logic              rom_req_valid_o,
   input bus_pkg::mem_req_t rom_req_o,
   input logic              rom_rsp_valid_i,
   input logic              dram_req_valid_o,
   input bus_pkg::mem_req_t dram_req_o,
   input logic              dram_rsp_valid_i
);

   timeunit 1ns;
   timeprecision 1ps;

   int occ;
   int fail_cnt = 0;

   // Requests accepted but not yet popped
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         occ <= 0;
      end else begin
         occ <= occ + int'(req_valid_i) - int'(fifo_pop);
      end
   end

   a_buffer_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
      occ <= `FABRIC_DEPTH)
      else begin
         $error("request buffer holds more than its depth");
         fail_cnt++;
      end

   a_penable_after_setup: assert property (@(posedge clk) disable iff (!rst_n_i)
      $rose(penable_o) |-> psel_o && $past(psel_o) && !$past(penable_o))
      else begin
         $error("penable raised without a setup cycle");
         fail_cnt++;
      end

   a_rom_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
      rom_req_valid_o && !rom_rsp_valid_i |=> rom_req_valid_o && $stable(rom_req_o))
      else begin
         $error("ROM request changed before its response");
         fail_cnt++;
      end

   a_dram_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
      dram_req_valid_o && !dram_rsp_valid_i |=> dram_req_valid_o && $stable(dram_req_o))
      else begin
         $error("DRAM request changed before its response");
         fail_cnt++;
      end

endmodule

bind soc_fabric soc_fabric_assert i_soc_fabric_assert (.*);

// File: dv/soc_fabric_tb.sv
// --------------------
// SoC fabric testbench
// --------------------

`include "soc_map_consts.svh"

module soc_fabric_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int RESET_CYCLES = 10;
   localparam int NUM_REQS = 15;
   // Send, pop, APB setup, up to four access cycles, response and slack
   localparam int REQ_CYCLES = 10;
   localparam int MAX_CYCLES = 2 * (RESET_CYCLES + NUM_REQS * REQ_CYCLES);

   logic clk;
   logic rst_n_i;
   logic req_valid_i;
   bus_pkg::bus_req_t req_i;
   logic credit_o;
   logic rsp_valid_o;
   bus_pkg::bus_rsp_t rsp_o;
   logic rom_req_valid_o;
   bus_pkg::mem_req_t rom_req_o;
   logic rom_rsp_valid_i;
   bus_pkg::data_t rom_rsp_data_i;
   logic dram_req_valid_o;
   bus_pkg::mem_req_t dram_req_o;
   logic dram_rsp_valid_i;
   bus_pkg::data_t dram_rsp_data_i;
   logic psel_o;
   logic penable_o;
   logic pwrite_o;
   logic [`APB_ADDR_W-1:0] paddr_o;
   logic [`APB_DATA_W-1:0] pwdata_o;
   logic [`APB_DATA_W-1:0] prdata_i;
   logic pready_i;
   logic pslverr_i;

   int unsigned seed = 74021;
   int errors = 0;
   int credits = `FABRIC_DEPTH;
   int credit_pulses = 0;
   int cycles = 0;
   int rom_wait;
   int dram_wait;
   int apb_wait;
   logic rom_busy = 1'b0;
   logic dram_busy = 1'b0;
   logic apb_busy = 1'b0;
   logic apb_err_inject = 1'b0;
   logic touched = 1'b0;
   logic [31:0] apb_last_addr;
   logic [31:0] apb_word;
   string test_name = "init";
   bus_pkg::bus_rsp_t exp_q[$];
   bus_pkg::data_t dram_mem[logic [31:0]];
   logic [31:0] apb_mem[logic [31:0]];

   soc_fabric i_soc_fabric (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic int unsigned lcg_next();
      seed = seed * 32'd1103515245 + 32'd12345;
      return seed >> 8;
   endfunction

   // ROM contents from the full offset
   function automatic bus_pkg::data_t rom_word(logic [31:0] off);
      return {off ^ 32'hA5A5_0000, ~off};
   endfunction

   // --------------------
   // Target models
   always @(negedge clk) begin
      rom_rsp_valid_i = 1'b0;
      if (rom_req_valid_o) begin
         if (!rom_busy) begin
            rom_busy = 1'b1;
            rom_wait = int'(lcg_next() % 4);
         end
         if (rom_wait == 0) begin
            rom_rsp_valid_i = 1'b1;
            rom_rsp_data_i = rom_word(rom_req_o.offset);
            rom_busy = 1'b0;
         end else begin
            rom_wait--;
         end
      end
   end

   always @(negedge clk) begin
      dram_rsp_valid_i = 1'b0;
      if (dram_req_valid_o) begin
         if (!dram_busy) begin
            dram_busy = 1'b1;
            dram_wait = int'(lcg_next() % 4);
         end
         if (dram_wait == 0) begin
            dram_rsp_valid_i = 1'b1;
            dram_rsp_data_i = '0;
            if (dram_req_o.write) begin
               dram_mem[dram_req_o.offset] = dram_req_o.data;
            end else if (dram_mem.exists(dram_req_o.offset)) begin
               dram_rsp_data_i = dram_mem[dram_req_o.offset];
            end
            dram_busy = 1'b0;
         end else begin
            dram_wait--;
         end
      end
   end

   always @(negedge clk) begin
      pready_i = 1'b0;
      if (psel_o && penable_o) begin
         if (!apb_busy) begin
            apb_busy = 1'b1;
            apb_wait = int'(lcg_next() % 4);
         end
         if (apb_wait == 0) begin
            pready_i = 1'b1;
            pslverr_i = apb_err_inject;
            apb_last_addr = paddr_o;
            prdata_i = '0;
            if (pwrite_o) begin
               apb_mem[paddr_o] = pwdata_o;
            end else if (apb_mem.exists(paddr_o)) begin
               prdata_i = apb_mem[paddr_o];
            end
            apb_busy = 1'b0;
         end else begin
            apb_wait--;
         end
      end
   end

   // --------------------
   // Master side monitors
   always @(negedge clk) begin
      if (credit_o) begin
         credits++;
         credit_pulses++;
      end
      if (rom_req_valid_o || dram_req_valid_o || psel_o) begin
         touched = 1'b1;
      end
      if (rsp_valid_o) begin
         assert (exp_q.size() != 0)
         else begin
            $display("Response arrived with no request outstanding in %s", test_name);
            errors++;
         end
         if (exp_q.size() != 0) begin
            assert (rsp_o === exp_q[0])
            else begin
               $display("ERROR %s: expected %h actual %h", test_name, exp_q[0], rsp_o);
               errors++;
            end
            void'(exp_q.pop_front());
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > MAX_CYCLES) begin
         $display("Timeout after %0d cycles in %s", cycles, test_name);
         $display("** FAIL **");
         $finish;
      end
   end

   // Called at a falling edge, returns one falling edge later
   task automatic send_req(input logic wr, input bus_pkg::addr_t addr,
                           input bus_pkg::data_t data, input bus_pkg::bus_rsp_t exp);
      while (credits == 0) @(negedge clk);
      req_valid_i = 1'b1;
      req_i = '{write: wr, addr: addr, data: data};
      credits--;
      exp_q.push_back(exp);
      @(negedge clk);
      req_valid_i = 1'b0;
   endtask

   task automatic drain();
      while (exp_q.size() != 0) @(negedge clk);
   endtask

   task automatic rom_read_test();
      logic [31:0] offs[4];
      test_name = "rom_read";
      offs = '{32'h0, 32'h8, 32'h1238, `ROM_LEN - 32'h8};
      assert (!credit_o && !rsp_valid_o && !rom_req_valid_o && !dram_req_valid_o
              && !psel_o && !penable_o)
      else begin
         $display("Control outputs not low after reset");
         errors++;
      end
      foreach (offs[i]) begin
         send_req(1'b0, `ROM_BASE + offs[i], '0, '{data: rom_word(offs[i]), err: 1'b0});
      end
      drain();
   endtask

   task automatic dram_test();
      bus_pkg::data_t d;
      test_name = "dram_write_read";
      d = {lcg_next(), lcg_next()};
      send_req(1'b1, `DRAM_BASE + 32'h40, d, '{data: '0, err: 1'b0});
      send_req(1'b0, `DRAM_BASE + 32'h40, '0, '{data: d, err: 1'b0});
      drain();
   endtask

   task automatic apb_test();
      bus_pkg::data_t d;
      test_name = "apb_write_read";
      d = {lcg_next(), lcg_next()};
      apb_word = d[31:0];
      send_req(1'b1, `APB_BASE + 32'h100, d, '{data: '0, err: 1'b0});
      drain();
      assert (apb_last_addr == 32'h100)
      else begin
         $display("ERROR %s: expected %h actual %h", test_name, 32'h100, apb_last_addr);
         errors++;
      end
      send_req(1'b0, `APB_BASE + 32'h100, '0, '{data: {32'h0, d[31:0]}, err: 1'b0});
      drain();
      apb_err_inject = 1'b1;
      send_req(1'b0, `APB_BASE + 32'h100, '0, '{data: {32'h0, d[31:0]}, err: 1'b1});
      drain();
      apb_err_inject = 1'b0;
   endtask

   task automatic unmapped_test();
      test_name = "unmapped";
      touched = 1'b0;
      send_req(1'b0, 32'h2000_0000, '0, '{data: '0, err: 1'b1});
      drain();
      assert (!touched)
      else begin
         $display("A target was accessed for an unmapped address");
         errors++;
      end
   endtask

   task automatic mixed_burst_test();
      bus_pkg::data_t d;
      int start;
      test_name = "mixed_back_to_back";
      d = {lcg_next(), lcg_next()};
      start = credit_pulses;
      send_req(1'b0, `ROM_BASE + 32'h20, '0, '{data: rom_word(32'h20), err: 1'b0});
      send_req(1'b1, `DRAM_BASE + 32'h80, d, '{data: '0, err: 1'b0});
      send_req(1'b0, `APB_BASE + 32'h100, '0, '{data: {32'h0, apb_word}, err: 1'b0});
      send_req(1'b0, 32'hF000_0000, '0, '{data: '0, err: 1'b1});
      drain();
      assert (credit_pulses - start == 4)
      else begin
         $display("ERROR %s: expected %0d actual %0d", test_name, 4, credit_pulses - start);
         errors++;
      end
      assert (credits == `FABRIC_DEPTH)
      else begin
         $display("Master does not hold all its credits after the burst in %s", test_name);
         errors++;
      end
      // Read back the DRAM word written in the burst
      send_req(1'b0, `DRAM_BASE + 32'h80, '0, '{data: d, err: 1'b0});
      drain();
   endtask

   initial begin
      rst_n_i = 1'b0;
      req_valid_i = 1'b0;
      req_i = '0;
      rom_rsp_valid_i = 1'b0;
      rom_rsp_data_i = '0;
      dram_rsp_valid_i = 1'b0;
      dram_rsp_data_i = '0;
      prdata_i = '0;
      pready_i = 1'b0;
      pslverr_i = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n_i = 1'b1;
      @(negedge clk);
      rom_read_test();
      dram_test();
      apb_test();
      unmapped_test();
      mixed_burst_test();
      repeat (4) @(negedge clk);
      $display("Errors: %0d check, %0d assertion", errors,
               i_soc_fabric.i_soc_fabric_assert.fail_cnt);
      if (errors == 0 && i_soc_fabric.i_soc_fabric_assert.fail_cnt == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// File: compile.f
+incdir+source
source/map_pkg.sv
source/bus_pkg.sv
source/addr_decoder.sv
source/req_fifo.sv
source/apb_bridge.sv
source/fabric_ctrl.sv
source/soc_fabric.sv
dv/soc_fabric_assert.sv
dv/soc_fabric_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module soc_fabric_tb \
   --Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q '\*\* PASS \*\*'; then
   exit 0
fi
exit 1
